// File: core_pkg.sv
package core_pkg;

    localparam int XLEN = 32;
    localparam int ILEN = 32;

    typedef logic [XLEN-1:0]   xword_t;
    typedef logic [ILEN-1:0]   insn_t;
    typedef logic [4:0]        reg_addr_t;
    typedef logic [XLEN/8-1:0] byte_mask_t;
    typedef logic [63:0]       order_t;

    localparam xword_t RESET_PC = 32'h0000_0000;
    localparam xword_t TRAP_VEC = 32'h0000_0100; // Taken on any illegal encoding.

    // Major opcodes of the supported subset.
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_EQ,
        ALU_NE
    } alu_op_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM_WAIT,
        ST_WB,
        ST_RETIRE
    } pipe_state_t;

endpackage

// File: core_retire_if.sv
`timescale 1ns/10ps

interface core_retire_if;
    import core_pkg::*;

    logic       n_valid;
    insn_t      n_insn;
    logic       n_trap;

    reg_addr_t  n_rs1_addr;
    reg_addr_t  n_rs2_addr;
    xword_t     n_rs1_rdata;
    xword_t     n_rs2_rdata;

    logic       n_rd_valid;  // Register file write strobe.
    reg_addr_t  n_rd_addr;
    xword_t     n_rd_wdata;

    logic       n_cf_change;
    xword_t     n_cf_target;

    xword_t     n_pc_rdata;
    xword_t     n_pc_wdata;

    logic       n_mem_req_valid;
    logic       n_mem_rsp_valid;
    xword_t     n_mem_addr;
    byte_mask_t n_mem_rmask;
    byte_mask_t n_mem_wmask;
    xword_t     n_mem_rdata;
    xword_t     n_mem_wdata;

    modport src (
        output n_valid, n_insn, n_trap,
        output n_rs1_addr, n_rs2_addr, n_rs1_rdata, n_rs2_rdata,
        output n_rd_valid, n_rd_addr, n_rd_wdata,
        output n_cf_change, n_cf_target, n_pc_rdata, n_pc_wdata,
        output n_mem_req_valid, n_mem_rsp_valid, n_mem_addr,
        output n_mem_rmask, n_mem_wmask, n_mem_rdata, n_mem_wdata
    );

    modport snk (
        input n_valid, n_insn, n_trap,
        input n_rs1_addr, n_rs2_addr, n_rs1_rdata, n_rs2_rdata,
        input n_rd_valid, n_rd_addr, n_rd_wdata,
        input n_cf_change, n_cf_target, n_pc_rdata, n_pc_wdata,
        input n_mem_req_valid, n_mem_rsp_valid, n_mem_addr,
        input n_mem_rmask, n_mem_wmask, n_mem_rdata, n_mem_wdata
    );

endinterface

// File: core_regfile.sv
`timescale 1ns/10ps

module core_regfile (
    input  logic                g_clk,
    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    output core_pkg::xword_t    rs1_rdata,
    output core_pkg::xword_t    rs2_rdata,
    input  logic                wen,
    input  core_pkg::reg_addr_t rd_addr,
    input  core_pkg::xword_t    rd_wdata
);
    import core_pkg::*;

    xword_t regs [32];

    always_ff @(posedge g_clk) begin
        regs[0] <= '0; // x0 storage held at zero.
        if (wen && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_wdata;
        end
    end

    assign rs1_rdata = regs[rs1_addr];
    assign rs2_rdata = regs[rs2_addr];

    // x0 reads as zero on both ports.
    a_x0_zero: assert property (@(posedge g_clk)
        ((rs1_addr == '0) |-> (rs1_rdata == '0)) and
        ((rs2_addr == '0) |-> (rs2_rdata == '0)));

endmodule

// File: core_alu.sv
`timescale 1ns/10ps

module core_alu (
    input  core_pkg::alu_op_t op,
    input  core_pkg::xword_t  a,
    input  core_pkg::xword_t  b,
    output core_pkg::xword_t  result
);
    import core_pkg::*;

    xword_t sum;
    xword_t diff;

    // Shared adder, also used for load and store addresses.
    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        case (op)
            ALU_ADD: result = sum;
            ALU_SUB: result = diff;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_EQ:  result = xword_t'(diff == '0); // Branch decision in bit 0.
            ALU_NE:  result = xword_t'(diff != '0);
            default: result = sum;
        endcase
    end

endmodule

// File: core_pipe.sv
`timescale 1ns/10ps

module core_pipe (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    output core_pkg::xword_t     imem_addr,
    input  core_pkg::insn_t      imem_rdata,
    output logic                 dmem_req,
    output logic                 dmem_we,
    output core_pkg::xword_t     dmem_addr,
    output core_pkg::byte_mask_t dmem_wmask,
    output core_pkg::xword_t     dmem_wdata,
    input  logic                 dmem_rsp,
    input  core_pkg::xword_t     dmem_rdata,
    output core_pkg::reg_addr_t  rs1_addr,
    output core_pkg::reg_addr_t  rs2_addr,
    input  core_pkg::xword_t     rs1_rdata,
    input  core_pkg::xword_t     rs2_rdata,
    output logic                 wen,
    output core_pkg::reg_addr_t  rd_addr,
    output core_pkg::xword_t     rd_wdata,
    output core_pkg::alu_op_t    alu_op,
    output core_pkg::xword_t     alu_a,
    output core_pkg::xword_t     alu_b,
    input  core_pkg::xword_t     alu_result,
    core_retire_if.src           ret
);
    import core_pkg::*;

    pipe_state_t state;
    pipe_state_t state_nxt;
    xword_t      pc;
    insn_t       insn;
    insn_t       insn_q;
    xword_t      rs1_q;
    xword_t      rs2_q;
    xword_t      res_q;
    xword_t      npc_q;
    xword_t      ld_q;
    logic        cf_q;
    logic        in_exec;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    xword_t      imm_i;
    xword_t      imm_s;
    xword_t      imm_b;
    xword_t      imm_j;
    xword_t      rs1_v;
    xword_t      rs2_v;
    xword_t      addr_v;
    xword_t      target;
    xword_t      npc;
    logic        taken;
    logic        legal;
    logic        is_alu;
    logic        is_load;
    logic        is_store;
    logic        is_br;
    logic        is_jal;

    assign in_exec = (state == ST_EXEC);

    // Instruction word arrives in EXEC and is held until retirement.
    assign insn   = in_exec ? imem_rdata : insn_q;
    assign rs1_v  = in_exec ? rs1_rdata : rs1_q;
    assign rs2_v  = in_exec ? rs2_rdata : rs2_q;
    assign addr_v = in_exec ? alu_result : res_q;

    assign opcode   = insn[6:0];
    assign funct3   = insn[14:12];
    assign funct7   = insn[31:25];
    assign rs1_addr = insn[19:15];
    assign rs2_addr = insn[24:20];
    assign rd_addr  = insn[11:7];

    assign imm_i = {{20{insn[31]}}, insn[31:20]};
    assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

    always_comb begin
        is_alu   = 1'b0;
        is_load  = 1'b0;
        is_store = 1'b0;
        is_br    = 1'b0;
        is_jal   = 1'b0;
        alu_op   = ALU_ADD;
        alu_a    = rs1_v;
        alu_b    = imm_i;
        case (opcode)
            OPC_OP_IMM: is_alu = (funct3 == 3'b000); // ADDI only.
            OPC_OP: begin
                alu_b  = rs2_v;
                is_alu = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op = ALU_ADD;
                    {7'h20, 3'b000}: alu_op = ALU_SUB;
                    {7'h00, 3'b111}: alu_op = ALU_AND;
                    {7'h00, 3'b110}: alu_op = ALU_OR;
                    {7'h00, 3'b100}: alu_op = ALU_XOR;
                    default:         is_alu = 1'b0;
                endcase
            end
            OPC_LOAD:  is_load = (funct3 == 3'b010);
            OPC_STORE: begin
                alu_b    = imm_s;
                is_store = (funct3 == 3'b010);
            end
            OPC_BRANCH: begin
                alu_b  = rs2_v;
                alu_op = funct3[0] ? ALU_NE : ALU_EQ;
                is_br  = (funct3[2:1] == 2'b00);
            end
            OPC_JAL: begin
                is_jal = 1'b1;
                alu_a  = pc;     // Link value.
                alu_b  = xword_t'(4);
            end
            default: begin
                is_alu = 1'b0;
            end
        endcase
    end

    assign legal  = is_alu | is_load | is_store | is_br | is_jal;
    assign taken  = is_jal | (is_br & alu_result[0]);
    assign target = pc + (is_jal ? imm_j : imm_b);
    assign npc    = !legal ? TRAP_VEC : (taken ? target : pc + xword_t'(4));

    always_comb begin
        state_nxt = state;
        case (state)
            ST_FETCH:    state_nxt = ST_EXEC;
            ST_EXEC:     state_nxt = (is_load || is_store) ? ST_MEM_WAIT : ST_RETIRE;
            ST_MEM_WAIT: if (dmem_rsp) state_nxt = is_load ? ST_WB : ST_RETIRE;
            ST_WB:       state_nxt = ST_RETIRE;
            ST_RETIRE:   state_nxt = ST_FETCH;
            default:     state_nxt = ST_FETCH;
        endcase
    end

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            state <= ST_FETCH;
            pc    <= RESET_PC;
        end else begin
            state <= state_nxt;
            if (state == ST_RETIRE) begin
                pc <= npc_q;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (in_exec) begin
            insn_q <= imem_rdata;
            rs1_q  <= rs1_rdata;
            rs2_q  <= rs2_rdata;
            res_q  <= alu_result; // Result, link or address.
            npc_q  <= npc;
            cf_q   <= taken;
        end
        if (dmem_rsp) begin
            ld_q <= dmem_rdata;
        end
    end

    assign imem_addr  = pc;
    assign dmem_req   = in_exec && (is_load || is_store);
    assign dmem_we    = is_store;
    assign dmem_addr  = (is_load || is_store) ? addr_v : '0;
    assign dmem_wmask = is_store ? '1 : '0;
    assign dmem_wdata = is_store ? rs2_v : '0;

    // Loads write in WB, everything else at retirement.
    assign wen      = (state == ST_WB) || ((state == ST_RETIRE) && (is_alu || is_jal));
    assign rd_wdata = is_load ? ld_q : res_q;

    assign ret.n_valid         = (state == ST_RETIRE);
    assign ret.n_insn          = insn;
    assign ret.n_trap          = !legal;
    assign ret.n_rs1_addr      = rs1_addr;
    assign ret.n_rs2_addr      = rs2_addr;
    assign ret.n_rs1_rdata     = rs1_v;
    assign ret.n_rs2_rdata     = rs2_v;
    assign ret.n_rd_valid      = wen;
    assign ret.n_rd_addr       = rd_addr;
    assign ret.n_rd_wdata      = rd_wdata;
    assign ret.n_cf_change     = (state == ST_RETIRE) && cf_q;
    assign ret.n_cf_target     = target;
    assign ret.n_pc_rdata      = pc;
    assign ret.n_pc_wdata      = npc_q;
    assign ret.n_mem_req_valid = dmem_req;
    assign ret.n_mem_rsp_valid = dmem_rsp && (state == ST_MEM_WAIT) && is_load;
    assign ret.n_mem_addr      = dmem_addr;
    assign ret.n_mem_rmask     = is_load ? '1 : '0;
    assign ret.n_mem_wmask     = dmem_wmask;
    assign ret.n_mem_rdata     = dmem_rdata;
    assign ret.n_mem_wdata     = dmem_wdata;

    // A response only ever finds the FSM waiting for it.
    a_rsp_in_wait: assert property (@(posedge g_clk) disable iff (!g_resetn)
        dmem_rsp |-> (state == ST_MEM_WAIT));

endmodule

// File: core_rvfi.sv
`timescale 1ns/10ps

module core_rvfi (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    core_retire_if.snk           ret,
    output logic                 rvfi_valid,
    output core_pkg::order_t     rvfi_order,
    output core_pkg::insn_t      rvfi_insn,
    output logic                 rvfi_trap,
    output core_pkg::reg_addr_t  rvfi_rs1_addr,
    output core_pkg::reg_addr_t  rvfi_rs2_addr,
    output core_pkg::xword_t     rvfi_rs1_rdata,
    output core_pkg::xword_t     rvfi_rs2_rdata,
    output core_pkg::reg_addr_t  rvfi_rd_addr,
    output core_pkg::xword_t     rvfi_rd_wdata,
    output core_pkg::xword_t     rvfi_pc_rdata,
    output core_pkg::xword_t     rvfi_pc_wdata,
    output core_pkg::xword_t     rvfi_mem_addr,
    output core_pkg::byte_mask_t rvfi_mem_rmask,
    output core_pkg::byte_mask_t rvfi_mem_wmask,
    output core_pkg::xword_t     rvfi_mem_rdata,
    output core_pkg::xword_t     rvfi_mem_wdata
);
    import core_pkg::*;

    logic hold_rd;
    logic hold_rd_nxt;

    // Set by an early write, cleared by the retirement it belongs to.
    assign hold_rd_nxt = hold_rd ? !ret.n_valid : (ret.n_rd_valid && !ret.n_valid);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rvfi_valid <= 1'b0;
            rvfi_order <= '0;
            hold_rd    <= 1'b0;
        end else begin
            rvfi_valid <= ret.n_valid;
            hold_rd    <= hold_rd_nxt;
            if (rvfi_valid) begin
                rvfi_order <= rvfi_order + order_t'(1); // Next record's index.
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (ret.n_valid) begin
            rvfi_insn      <= ret.n_insn;
            rvfi_trap      <= ret.n_trap;
            rvfi_rs1_addr  <= ret.n_rs1_addr;
            rvfi_rs2_addr  <= ret.n_rs2_addr;
            rvfi_rs1_rdata <= ret.n_rs1_rdata;
            rvfi_rs2_rdata <= ret.n_rs2_rdata;
            rvfi_pc_rdata  <= ret.n_pc_rdata;
        end
        if (ret.n_valid || ret.n_cf_change) begin
            rvfi_pc_wdata <= ret.n_cf_change ? ret.n_cf_target : ret.n_pc_wdata;
        end
    end

    always_ff @(posedge g_clk) begin
        if (ret.n_rd_valid || (ret.n_valid && !hold_rd)) begin
            rvfi_rd_addr <= ret.n_rd_valid ? ret.n_rd_addr : '0;
            if (ret.n_rd_valid && (ret.n_rd_addr != '0)) begin
                rvfi_rd_wdata <= ret.n_rd_wdata;
            end else begin
                rvfi_rd_wdata <= '0; // No write, or a write to x0.
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (ret.n_mem_req_valid || ret.n_valid) begin
            rvfi_mem_addr  <= ret.n_mem_addr;
            rvfi_mem_rmask <= ret.n_mem_rmask;
            rvfi_mem_wmask <= ret.n_mem_wmask;
            rvfi_mem_wdata <= ret.n_mem_wdata;
        end
        if (ret.n_mem_rsp_valid) begin
            rvfi_mem_rdata <= ret.n_mem_rdata;
        end
    end

    // The core retires at most once every three cycles.
    a_valid_pulse: assert property (@(posedge g_clk) disable iff (!g_resetn)
        rvfi_valid |=> !rvfi_valid);

endmodule

// File: core_top.sv
`timescale 1ns/10ps

module core_top (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    output core_pkg::xword_t     imem_addr,
    input  core_pkg::insn_t      imem_rdata,
    output logic                 dmem_req,
    output logic                 dmem_we,
    output core_pkg::xword_t     dmem_addr,
    output core_pkg::byte_mask_t dmem_wmask,
    output core_pkg::xword_t     dmem_wdata,
    input  logic                 dmem_rsp,
    input  core_pkg::xword_t     dmem_rdata,
    output logic                 rvfi_valid,
    output core_pkg::order_t     rvfi_order,
    output core_pkg::insn_t      rvfi_insn,
    output logic                 rvfi_trap,
    output core_pkg::reg_addr_t  rvfi_rs1_addr,
    output core_pkg::reg_addr_t  rvfi_rs2_addr,
    output core_pkg::xword_t     rvfi_rs1_rdata,
    output core_pkg::xword_t     rvfi_rs2_rdata,
    output core_pkg::reg_addr_t  rvfi_rd_addr,
    output core_pkg::xword_t     rvfi_rd_wdata,
    output core_pkg::xword_t     rvfi_pc_rdata,
    output core_pkg::xword_t     rvfi_pc_wdata,
    output core_pkg::xword_t     rvfi_mem_addr,
    output core_pkg::byte_mask_t rvfi_mem_rmask,
    output core_pkg::byte_mask_t rvfi_mem_wmask,
    output core_pkg::xword_t     rvfi_mem_rdata,
    output core_pkg::xword_t     rvfi_mem_wdata
);
    import core_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    xword_t    rs1_rdata;
    xword_t    rs2_rdata;
    xword_t    rd_wdata;
    logic      wen;
    alu_op_t   alu_op;
    xword_t    alu_a;
    xword_t    alu_b;
    xword_t    alu_result;

    core_retire_if i_ret ();

    core_pipe i_pipe (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata),
        .dmem_rsp   (dmem_rsp),
        .dmem_rdata (dmem_rdata),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_rdata  (rs1_rdata),
        .rs2_rdata  (rs2_rdata),
        .wen        (wen),
        .rd_addr    (rd_addr),
        .rd_wdata   (rd_wdata),
        .alu_op     (alu_op),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_result (alu_result),
        .ret        (i_ret.src)
    );

    core_regfile i_regfile (
        .g_clk     (g_clk),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_rdata (rs1_rdata),
        .rs2_rdata (rs2_rdata),
        .wen       (wen),
        .rd_addr   (rd_addr),
        .rd_wdata  (rd_wdata)
    );

    core_alu i_alu (
        .op     (alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    core_rvfi i_rvfi (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .ret            (i_ret.snk),
        .rvfi_valid     (rvfi_valid),
        .rvfi_order     (rvfi_order),
        .rvfi_insn      (rvfi_insn),
        .rvfi_trap      (rvfi_trap),
        .rvfi_rs1_addr  (rvfi_rs1_addr),
        .rvfi_rs2_addr  (rvfi_rs2_addr),
        .rvfi_rs1_rdata (rvfi_rs1_rdata),
        .rvfi_rs2_rdata (rvfi_rs2_rdata),
        .rvfi_rd_addr   (rvfi_rd_addr),
        .rvfi_rd_wdata  (rvfi_rd_wdata),
        .rvfi_pc_rdata  (rvfi_pc_rdata),
        .rvfi_pc_wdata  (rvfi_pc_wdata),
        .rvfi_mem_addr  (rvfi_mem_addr),
        .rvfi_mem_rmask (rvfi_mem_rmask),
        .rvfi_mem_wmask (rvfi_mem_wmask),
        .rvfi_mem_rdata (rvfi_mem_rdata),
        .rvfi_mem_wdata (rvfi_mem_wdata)
    );

endmodule

// File: core_tb.sv
`timescale 1ns/10ps

module core_tb;
    import core_pkg::*;

    // One retirement record expected from the trace port.
    typedef struct packed {
        insn_t      insn;
        xword_t     pc_rdata;
        xword_t     pc_wdata;
        reg_addr_t  rd_addr;
        xword_t     rd_wdata;
        logic       trap;
        xword_t     mem_addr;
        byte_mask_t mem_wmask;
    } step_t;

    localparam int TIMEOUT_CYCLES = 60;

    logic       g_clk;
    logic       g_resetn;
    xword_t     imem_addr;
    insn_t      imem_rdata = '0;
    logic       dmem_req;
    logic       dmem_we;
    xword_t     dmem_addr;
    byte_mask_t dmem_wmask;
    xword_t     dmem_wdata;
    logic       dmem_rsp = 1'b0;
    xword_t     dmem_rdata = '0;
    logic       rvfi_valid;
    order_t     rvfi_order;
    insn_t      rvfi_insn;
    logic       rvfi_trap;
    reg_addr_t  rvfi_rs1_addr;
    reg_addr_t  rvfi_rs2_addr;
    xword_t     rvfi_rs1_rdata;
    xword_t     rvfi_rs2_rdata;
    reg_addr_t  rvfi_rd_addr;
    xword_t     rvfi_rd_wdata;
    xword_t     rvfi_pc_rdata;
    xword_t     rvfi_pc_wdata;
    xword_t     rvfi_mem_addr;
    byte_mask_t rvfi_mem_rmask;
    byte_mask_t rvfi_mem_wmask;
    xword_t     rvfi_mem_rdata;
    xword_t     rvfi_mem_wdata;

    xword_t      imem [0:127];
    xword_t      dmem [0:63];
    xword_t      xreg [0:31];
    logic [31:0] known = 32'h1;
    step_t       steps[$];
    string       names[$];
    logic [15:0] lfsr = 16'd66;
    logic [1:0]  delay;
    logic [5:0]  rsp_index;
    logic        rsp_pending = 1'b0;
    int          rsp_cycles = 0;
    int          value_errors = 0;
    int          timeout_errors = 0;

    core_top i_dut (.*);

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;
    end

    // Taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
    endfunction

    function automatic insn_t itype(input int opc, input int f3, input int rd,
                                    input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic insn_t rtype(input int f7, input int f3, input int rd,
                                    input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic insn_t stype(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic insn_t btype(input int f3, input int rs1, input int rs2, input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic insn_t jtype(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    task automatic add_step(input string name, input insn_t insn, input xword_t pc_r,
                            input xword_t pc_w, input reg_addr_t rd, input xword_t rd_w,
                            input logic trap, input xword_t maddr, input byte_mask_t wmask);
        step_t s;
        s = '{insn, pc_r, pc_w, rd, rd_w, trap, maddr, wmask};
        steps.push_back(s);
        names.push_back(name);
    endtask

    task automatic check_field(input string test, input string field,
                               input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            $display("ERR %s %s: expected %0h actual %0h", test, field, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_step(input int k);
        step_t     s;
        reg_addr_t ra;
        reg_addr_t rb;
        s  = steps[k];
        ra = s.insn[19:15];
        rb = s.insn[24:20];
        check_field(names[k], "order", 64'(k), 64'(rvfi_order));
        check_field(names[k], "insn", 64'(s.insn), 64'(rvfi_insn));
        check_field(names[k], "pc_rdata", 64'(s.pc_rdata), 64'(rvfi_pc_rdata));
        check_field(names[k], "pc_wdata", 64'(s.pc_wdata), 64'(rvfi_pc_wdata));
        check_field(names[k], "rd_addr", 64'(s.rd_addr), 64'(rvfi_rd_addr));
        check_field(names[k], "rd_wdata", 64'(s.rd_wdata), 64'(rvfi_rd_wdata));
        check_field(names[k], "trap", 64'(s.trap), 64'(rvfi_trap));
        check_field(names[k], "mem_addr", 64'(s.mem_addr), 64'(rvfi_mem_addr));
        check_field(names[k], "mem_wmask", 64'(s.mem_wmask), 64'(rvfi_mem_wmask));
        check_field(names[k], "rs1_addr", 64'(ra), 64'(rvfi_rs1_addr));
        check_field(names[k], "rs2_addr", 64'(rb), 64'(rvfi_rs2_addr));
        // Source data is only known for registers written earlier.
        if (known[ra]) begin
            check_field(names[k], "rs1_rdata", 64'(xreg[ra]), 64'(rvfi_rs1_rdata));
        end
        if (known[rb]) begin
            check_field(names[k], "rs2_rdata", 64'(xreg[rb]), 64'(rvfi_rs2_rdata));
        end
        if (s.insn[6:0] == 7'h03) begin
            check_field(names[k], "mem_rmask", 64'hf, 64'(rvfi_mem_rmask));
            check_field(names[k], "mem_rdata", 64'(s.rd_wdata), 64'(rvfi_mem_rdata));
        end else begin
            check_field(names[k], "mem_rmask", 64'h0, 64'(rvfi_mem_rmask));
        end
        if (s.mem_wmask != '0) begin
            check_field(names[k], "mem_wdata", 64'(xreg[rb]), 64'(rvfi_mem_wdata));
        end
        if (s.rd_addr != '0) begin
            xreg[s.rd_addr]  = s.rd_wdata;
            known[s.rd_addr] = 1'b1;
        end
    endtask

    task automatic wait_retire(output bit seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge g_clk); // Trace fields are settled here.
            if (rvfi_valid === 1'b1) begin
                seen = 1'b1;
            end
            cycles++;
        end
    endtask

    // One-cycle instruction read.
    always @(posedge g_clk) begin
        imem_rdata <= imem[imem_addr[8:2]];
    end

    // Data memory with a response one to four cycles after the request.
    always @(posedge g_clk) begin
        dmem_rsp <= 1'b0;
        if (!g_resetn) begin
            rsp_pending = 1'b0;
            for (int i = 0; i < 64; i++) begin
                dmem[i] = 32'hda7a_0000 ^ xword_t'(i * 4);
            end
        end else begin
            if (dmem_req) begin
                lfsr = lfsr_next(lfsr);
                delay[0] = lfsr[0];
                lfsr = lfsr_next(lfsr);
                delay[1] = lfsr[0];
                rsp_cycles = int'(delay) + 1;
                rsp_pending = 1'b1;
                rsp_index = dmem_addr[7:2];
                if (dmem_we && dmem_wmask == 4'hf) begin
                    dmem[dmem_addr[7:2]] = dmem_wdata;
                end
            end
            if (rsp_pending) begin
                if (rsp_cycles == 1) begin
                    dmem_rsp    <= 1'b1;
                    dmem_rdata  <= dmem[rsp_index];
                    rsp_pending = 1'b0;
                end else begin
                    rsp_cycles = rsp_cycles - 1;
                end
            end
        end
    end

    initial begin
        bit seen;
        g_resetn = 1'b0;
        xreg[0] = '0;
        for (int i = 0; i < 128; i++) begin
            imem[i] = (xword_t'(i * 4) << 7) | 32'h7f; // Opcode 0x7f traps.
        end

        add_step("addi_x1", itype('h13, 0, 1, 0, 5),
                 32'h000, 32'h004, 5'd1, 32'd5, 1'b0, 32'h0, 4'h0);
        add_step("addi_x2", itype('h13, 0, 2, 0, 12),
                 32'h004, 32'h008, 5'd2, 32'd12, 1'b0, 32'h0, 4'h0);
        add_step("add", rtype('h00, 0, 3, 1, 2),
                 32'h008, 32'h00c, 5'd3, 32'd17, 1'b0, 32'h0, 4'h0);
        add_step("sub", rtype('h20, 0, 4, 2, 1),
                 32'h00c, 32'h010, 5'd4, 32'd7, 1'b0, 32'h0, 4'h0);
        add_step("and", rtype('h00, 7, 5, 1, 2),
                 32'h010, 32'h014, 5'd5, 32'd4, 1'b0, 32'h0, 4'h0);
        add_step("or", rtype('h00, 6, 6, 1, 2),
                 32'h014, 32'h018, 5'd6, 32'd13, 1'b0, 32'h0, 4'h0);
        add_step("xor", rtype('h00, 4, 7, 1, 2),
                 32'h018, 32'h01c, 5'd7, 32'd9, 1'b0, 32'h0, 4'h0);
        add_step("addi_x0", itype('h13, 0, 0, 1, 3),
                 32'h01c, 32'h020, 5'd0, 32'd0, 1'b0, 32'h0, 4'h0);
        add_step("addi_base", itype('h13, 0, 8, 0, 'h40),
                 32'h020, 32'h024, 5'd8, 32'h40, 1'b0, 32'h0, 4'h0);
        add_step("sw_44", stype(3, 8, 4),
                 32'h024, 32'h028, 5'd0, 32'd0, 1'b0, 32'h44, 4'hf);
        add_step("lw_44", itype('h03, 2, 9, 8, 4),
                 32'h028, 32'h02c, 5'd9, 32'd17, 1'b0, 32'h44, 4'h0);
        add_step("beq_taken", btype(0, 9, 3, 12),
                 32'h02c, 32'h038, 5'd0, 32'd0, 1'b0, 32'h0, 4'h0);
        add_step("jal", jtype(10, 16),
                 32'h038, 32'h048, 5'd10, 32'h3c, 1'b0, 32'h0, 4'h0);
        add_step("add_link", rtype('h00, 0, 11, 10, 9),
                 32'h048, 32'h04c, 5'd11, 32'h4d, 1'b0, 32'h0, 4'h0);
        add_step("illegal", 32'hffff_ffff,
                 32'h04c, 32'h100, 5'd0, 32'd0, 1'b1, 32'h0, 4'h0);
        add_step("addi_neg", itype('h13, 0, 12, 0, -1),
                 32'h100, 32'h104, 5'd12, 32'hffff_ffff, 1'b0, 32'h0, 4'h0);
        add_step("sw_40", stype(12, 8, 0),
                 32'h104, 32'h108, 5'd0, 32'd0, 1'b0, 32'h40, 4'hf);
        add_step("lw_40", itype('h03, 2, 13, 8, 0),
                 32'h108, 32'h10c, 5'd13, 32'hffff_ffff, 1'b0, 32'h40, 4'h0);
        add_step("bne_not_taken", btype(1, 1, 1, 8),
                 32'h10c, 32'h110, 5'd0, 32'd0, 1'b0, 32'h0, 4'h0);
        add_step("xor_load", rtype('h00, 4, 14, 13, 1),
                 32'h110, 32'h114, 5'd14, 32'hffff_fffa, 1'b0, 32'h0, 4'h0);

        foreach (steps[k]) begin
            imem[steps[k].pc_rdata[8:2]] = steps[k].insn;
        end

        repeat (8) @(posedge g_clk);
        g_resetn <= 1'b1;

        for (int k = 0; k < steps.size(); k++) begin
            wait_retire(seen);
            if (!seen) begin
                $display("No retirement arrived for %s within %0d cycles",
                         names[k], TIMEOUT_CYCLES);
                timeout_errors++;
                break;
            end
            check_step(k);
        end

        $display("Errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
core_pkg.sv
core_retire_if.sv
core_regfile.sv
core_alu.sv
core_pipe.sv
core_rvfi.sv
core_top.sv
core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
		echo "FAIL: no result line in $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
